// File: verilog/cmac_geom_pkg.sv
`default_nettype none

// ======================================================================
// geometry of one cmac slice
// ======================================================================
package cmac_geom_pkg;

  // channels per atom, one feature element each
  parameter int CMAC_ATOMC = 8;

  // kernels per atom, split evenly over the two mac halves
  parameter int CMAC_ATOMK = 8;

  // operand width of feature and weight elements
  parameter int CMAC_DATA_WIDTH = 8;

  // pipeline depth of one mac half, product register included
  parameter int CMAC_MAC_LATENCY = 2;

  // retiming depth of the output stage
  parameter int CMAC_RT_LATENCY = 2;

  // full product width plus carry growth over all channels
  // 8-bit operands over 8 channels give 19 bits
  function automatic int cmac_result_width(input int data_width, input int atomc);
    return 2 * data_width + $clog2(atomc);
  endfunction

endpackage

`default_nettype wire

// File: verilog/cmac_pkt_pkg.sv
`default_nettype none

// ======================================================================
// stripe packet descriptor and operand modes
// ======================================================================
package cmac_pkt_pkg;

  // descriptor travelling with every atom towards the accumulator
  parameter int CMAC_PD_WIDTH = 9;

  // bits 4:0 and 8:7 are opaque here and just pass through
  // stripe end marks the last atom of a stripe
  parameter int PD_STRIPE_END_BIT = 5;

  // layer end marks the last stripe of a layer
  parameter int PD_LAYER_END_BIT = 6;

  // operand signedness for both feature and weight elements
  // unsigned reads operands as 0..2^n-1
  // signed reads them as two's complement
  typedef enum logic {
    sign_unsigned = 1'b0,
    sign_signed   = 1'b1
  } cmac_sign_e;

endpackage

`default_nettype wire

// File: verilog/cmac_in_if.sv
`default_nettype none

// one input atom, fanned out to both mac halves
interface cmac_in_if
  import cmac_geom_pkg::*;
#(
  parameter int ATOMC      = CMAC_ATOMC,
  parameter int ATOMK      = CMAC_ATOMK,
  parameter int DATA_WIDTH = CMAC_DATA_WIDTH
);

  // feature elements, one per channel
  logic [ATOMC-1:0][DATA_WIDTH-1:0]            dat;
  // channel enables, a clear bit means the element is zero
  logic [ATOMC-1:0]                            dat_mask;
  // weights, kernel major then channel
  logic [ATOMK-1:0][ATOMC-1:0][DATA_WIDTH-1:0] wt;
  // kernel enables
  logic [ATOMK-1:0]                            wt_mask;
  // atom valid, no handshake
  logic                                        pvld;

  modport src (output dat, output dat_mask, output wt, output wt_mask, output pvld);
  modport snk (input dat, input dat_mask, input wt, input wt_mask, input pvld);

endinterface

`default_nettype wire

// File: verilog/cmac_mac_half.sv
`default_nettype none

// dot products for ATOMK_HALF kernels starting at KERNEL_BASE
module cmac_mac_half
  import cmac_geom_pkg::*;
  import cmac_pkt_pkg::*;
#(
  parameter int ATOMC        = CMAC_ATOMC,
  parameter int ATOMK_HALF   = CMAC_ATOMK / 2,
  parameter int DATA_WIDTH   = CMAC_DATA_WIDTH,
  parameter int MAC_LATENCY  = CMAC_MAC_LATENCY,
  parameter int KERNEL_BASE  = 0,
  localparam int RESULT_WIDTH = cmac_result_width(DATA_WIDTH, ATOMC)
) (
  input  wire logic                                   nvdla_core_clk,
  input  wire logic                                   reset,
  input  wire cmac_sign_e                             sign_mode,
  cmac_in_if.snk                                      atom,
  output logic [ATOMK_HALF-1:0][RESULT_WIDTH-1:0]     res_data,
  output logic [ATOMK_HALF-1:0]                       res_mask,
  output logic                                        res_pvld
);

  // one extra bit holds 255*255 as a positive signed value
  localparam int PROD_W = 2 * DATA_WIDTH + 1;

  // ======================================================================
  // stage 1: masked products
  // ======================================================================

  // operands widened by one bit, msb copied only in signed mode
  function automatic logic signed [PROD_W-1:0] mul_elem(
    input logic [DATA_WIDTH-1:0] a,
    input logic [DATA_WIDTH-1:0] b,
    input logic                  en,
    input cmac_sign_e            mode
  );
    logic signed [DATA_WIDTH:0] a_ext;
    logic signed [DATA_WIDTH:0] b_ext;
    logic signed [PROD_W-1:0]   prod;
    a_ext = {(mode == sign_signed) & a[DATA_WIDTH-1], a};
    b_ext = {(mode == sign_signed) & b[DATA_WIDTH-1], b};
    prod  = a_ext * b_ext;
    // disabled channel contributes nothing
    return en ? prod : '0;
  endfunction

  logic signed [PROD_W-1:0] prod_q [ATOMK_HALF][ATOMC];
  logic [ATOMK_HALF-1:0]    mask_q1;
  logic                     pvld_q1;

  // control flops of stage 1
  always_ff @(posedge nvdla_core_clk) begin
    if (reset) begin
      pvld_q1 <= 1'b0;
      mask_q1 <= '0;
    end else begin
      pvld_q1 <= atom.pvld;
      mask_q1 <= atom.pvld ? atom.wt_mask[KERNEL_BASE +: ATOMK_HALF] : '0;
    end
  end

  // product flops, only written for live kernels
  always_ff @(posedge nvdla_core_clk) begin
    for (int k = 0; k < ATOMK_HALF; k++) begin
      if (atom.pvld && atom.wt_mask[KERNEL_BASE + k]) begin
        for (int c = 0; c < ATOMC; c++) begin
          prod_q[k][c] <= mul_elem(atom.dat[c], atom.wt[KERNEL_BASE + k][c],
                                   atom.dat_mask[c], sign_mode);
        end
      end
    end
  end

  // ======================================================================
  // adder tree and delay stages
  // ======================================================================

  logic [ATOMK_HALF-1:0][RESULT_WIDTH-1:0] sum_d;

  // sign extension keeps signed sums exact, unsigned products are positive
  always_comb begin : p_sum
    logic signed [RESULT_WIDTH-1:0] acc;
    for (int k = 0; k < ATOMK_HALF; k++) begin
      acc = '0;
      for (int c = 0; c < ATOMC; c++) begin
        acc = acc + RESULT_WIDTH'(prod_q[k][c]);
      end
      sum_d[k] = acc;
    end
  end

  // stage chain, index 0 is the sum right after the product flops
  wire [ATOMK_HALF-1:0][RESULT_WIDTH-1:0] chain_data [MAC_LATENCY];
  wire [ATOMK_HALF-1:0]                   chain_mask [MAC_LATENCY];
  wire                                    chain_pvld [MAC_LATENCY];

  assign chain_data[0] = sum_d;
  assign chain_mask[0] = mask_q1;
  assign chain_pvld[0] = pvld_q1;

  for (genvar s = 1; s < MAC_LATENCY; s++) begin : g_dly
    logic [ATOMK_HALF-1:0][RESULT_WIDTH-1:0] data_q;
    logic [ATOMK_HALF-1:0]                   mask_q;
    logic                                    pvld_q;

    always_ff @(posedge nvdla_core_clk) begin
      if (reset) begin
        pvld_q <= 1'b0;
        mask_q <= '0;
      end else begin
        pvld_q <= chain_pvld[s-1];
        mask_q <= chain_mask[s-1];
      end
    end

    // each kernel result moves only under its own mask bit
    always_ff @(posedge nvdla_core_clk) begin
      for (int k = 0; k < ATOMK_HALF; k++) begin
        if (chain_mask[s-1][k]) begin
          data_q[k] <= chain_data[s-1][k];
        end
      end
    end

    assign chain_data[s] = data_q;
    assign chain_mask[s] = mask_q;
    assign chain_pvld[s] = pvld_q;
  end

  assign res_data = chain_data[MAC_LATENCY-1];
  assign res_mask = chain_mask[MAC_LATENCY-1];
  assign res_pvld = chain_pvld[MAC_LATENCY-1];

  // the accumulator trusts mask only under valid
  a_mask_needs_pvld: assert property (
    @(posedge nvdla_core_clk) disable iff (reset) !res_pvld |-> (res_mask == '0)
  );

endmodule

`default_nettype wire

// File: verilog/cmac_rt_out.sv
`default_nettype none

// joins both halves with the descriptor and retimes towards the accumulator
module cmac_rt_out
  import cmac_geom_pkg::*;
  import cmac_pkt_pkg::*;
#(
  parameter int ATOMK        = CMAC_ATOMK,
  parameter int RESULT_WIDTH = cmac_result_width(CMAC_DATA_WIDTH, CMAC_ATOMC),
  parameter int MAC_LATENCY  = CMAC_MAC_LATENCY,
  parameter int RT_LATENCY   = CMAC_RT_LATENCY
) (
  input  wire logic                                  nvdla_core_clk,
  input  wire logic                                  reset,
  input  wire logic [CMAC_PD_WIDTH-1:0]              in_pd,
  input  wire logic                                  in_pvld,
  input  wire logic [ATOMK/2-1:0][RESULT_WIDTH-1:0]  a_data,
  input  wire logic [ATOMK/2-1:0]                    a_mask,
  input  wire logic                                  a_pvld,
  input  wire logic [ATOMK/2-1:0][RESULT_WIDTH-1:0]  b_data,
  input  wire logic [ATOMK/2-1:0]                    b_mask,
  input  wire logic                                  b_pvld,
  output logic [ATOMK-1:0][RESULT_WIDTH-1:0]         mac2accu_data,
  output logic [ATOMK-1:0]                           mac2accu_mask,
  output logic [CMAC_PD_WIDTH-1:0]                   mac2accu_pd,
  output logic                                       mac2accu_pvld,
  output logic                                       dp2reg_done
);

  // ======================================================================
  // descriptor alignment with the mac halves
  // ======================================================================

  wire [CMAC_PD_WIDTH-1:0] pd_chain     [MAC_LATENCY+1];
  wire                     pd_vld_chain [MAC_LATENCY+1];

  assign pd_chain[0]     = in_pd;
  assign pd_vld_chain[0] = in_pvld;

  for (genvar s = 0; s < MAC_LATENCY; s++) begin : g_pd_align
    logic [CMAC_PD_WIDTH-1:0] pd_q;
    logic                     vld_q;

    // descriptor holds its last value between atoms
    always_ff @(posedge nvdla_core_clk) begin
      if (reset) begin
        vld_q <= 1'b0;
        pd_q  <= '0;
      end else begin
        vld_q <= pd_vld_chain[s];
        if (pd_vld_chain[s]) begin
          pd_q <= pd_chain[s];
        end
      end
    end

    assign pd_chain[s+1]     = pd_q;
    assign pd_vld_chain[s+1] = vld_q;
  end

  // ======================================================================
  // combine point
  // ======================================================================

  // half a holds the low kernels
  wire [CMAC_PD_WIDTH-1:0] aligned_pd = pd_chain[MAC_LATENCY];
  wire                     layer_done = a_pvld & aligned_pd[PD_LAYER_END_BIT] &
                                        aligned_pd[PD_STRIPE_END_BIT];

  // ======================================================================
  // output retiming
  // ======================================================================

  wire [ATOMK-1:0][RESULT_WIDTH-1:0] rt_data [RT_LATENCY+1];
  wire [ATOMK-1:0]                   rt_mask [RT_LATENCY+1];
  wire [CMAC_PD_WIDTH-1:0]           rt_pd   [RT_LATENCY+1];
  wire                               rt_pvld [RT_LATENCY+1];

  assign rt_data[0] = {b_data, a_data};
  assign rt_mask[0] = {b_mask, a_mask};
  assign rt_pd[0]   = aligned_pd;
  assign rt_pvld[0] = a_pvld;

  for (genvar s = 0; s < RT_LATENCY; s++) begin : g_rt
    logic [ATOMK-1:0][RESULT_WIDTH-1:0] data_q;
    logic [ATOMK-1:0]                   mask_q;
    logic [CMAC_PD_WIDTH-1:0]           pd_q;
    logic                               pvld_q;

    always_ff @(posedge nvdla_core_clk) begin
      if (reset) begin
        pvld_q <= 1'b0;
        mask_q <= '0;
        pd_q   <= '0;
      end else begin
        pvld_q <= rt_pvld[s];
        mask_q <= rt_mask[s];
        if (rt_pvld[s]) begin
          pd_q <= rt_pd[s];
        end
      end
    end

    // result flops gated per kernel
    always_ff @(posedge nvdla_core_clk) begin
      for (int k = 0; k < ATOMK; k++) begin
        if (rt_mask[s][k]) begin
          data_q[k] <= rt_data[s][k];
        end
      end
    end

    assign rt_data[s+1] = data_q;
    assign rt_mask[s+1] = mask_q;
    assign rt_pd[s+1]   = pd_q;
    assign rt_pvld[s+1] = pvld_q;
  end

  assign mac2accu_data = rt_data[RT_LATENCY];
  assign mac2accu_mask = rt_mask[RT_LATENCY];
  assign mac2accu_pd   = rt_pd[RT_LATENCY];
  assign mac2accu_pvld = rt_pvld[RT_LATENCY];

  // ======================================================================
  // layer done, one cycle behind the last beat
  // ======================================================================

  wire done_chain [RT_LATENCY+2];

  assign done_chain[0] = layer_done;

  for (genvar s = 0; s <= RT_LATENCY; s++) begin : g_done
    logic done_q;

    always_ff @(posedge nvdla_core_clk) begin
      if (reset) begin
        done_q <= 1'b0;
      end else begin
        done_q <= done_chain[s];
      end
    end

    assign done_chain[s+1] = done_q;
  end

  assign dp2reg_done = done_chain[RT_LATENCY+1];

  // both halves see the same atom stream, so they step together
  a_halves_in_step: assert property (
    @(posedge nvdla_core_clk) disable iff (reset) a_pvld == b_pvld
  );

  // descriptor delay must track the mac half depth
  a_pd_aligned: assert property (
    @(posedge nvdla_core_clk) disable iff (reset) pd_vld_chain[MAC_LATENCY] == a_pvld
  );

endmodule

`default_nettype wire

// File: verilog/cmac_core.sv
`default_nettype none

// cmac slice top: config capture, atom fan-out, two mac halves, output stage
module cmac_core
  import cmac_geom_pkg::*;
  import cmac_pkt_pkg::*;
#(
  parameter int ATOMC        = CMAC_ATOMC,
  // must be even, the halves split it
  parameter int ATOMK        = CMAC_ATOMK,
  parameter int DATA_WIDTH   = CMAC_DATA_WIDTH,
  parameter int MAC_LATENCY  = CMAC_MAC_LATENCY,
  parameter int RT_LATENCY   = CMAC_RT_LATENCY,
  localparam int RESULT_WIDTH = cmac_result_width(DATA_WIDTH, ATOMC)
) (
  input  wire logic                                nvdla_core_clk,
  input  wire logic                                reset,
  input  wire logic                                cfg_reg_en,
  input  wire logic                                cfg_sign,
  input  wire logic [ATOMC*DATA_WIDTH-1:0]         in_dat,
  input  wire logic [ATOMC-1:0]                    in_dat_mask,
  input  wire logic [ATOMK*ATOMC*DATA_WIDTH-1:0]   in_wt,
  input  wire logic [ATOMK-1:0]                    in_wt_mask,
  input  wire logic [CMAC_PD_WIDTH-1:0]            in_pd,
  input  wire logic                                in_pvld,
  output logic [ATOMK*RESULT_WIDTH-1:0]            mac2accu_data,
  output logic [ATOMK-1:0]                         mac2accu_mask,
  output logic [CMAC_PD_WIDTH-1:0]                 mac2accu_pd,
  output logic                                     mac2accu_pvld,
  output logic                                     dp2reg_done
);

  localparam int ATOMK_HALF = ATOMK / 2;

  // ======================================================================
  // config register
  // ======================================================================

  // new mode takes effect on the atom after the strobe edge
  cmac_sign_e sign_mode;

  always_ff @(posedge nvdla_core_clk) begin
    if (reset) begin
      sign_mode <= sign_unsigned;
    end else if (cfg_reg_en) begin
      sign_mode <= cmac_sign_e'(cfg_sign);
    end
  end

  // ======================================================================
  // atom fan-out
  // ======================================================================

  cmac_in_if #(
    .ATOMC      (ATOMC),
    .ATOMK      (ATOMK),
    .DATA_WIDTH (DATA_WIDTH)
  ) u_atom ();

  // flat ports map straight onto the packed fields
  // weight of kernel k channel c sits at element k*ATOMC+c
  assign u_atom.dat      = in_dat;
  assign u_atom.dat_mask = in_dat_mask;
  assign u_atom.wt       = in_wt;
  assign u_atom.wt_mask  = in_wt_mask;
  assign u_atom.pvld     = in_pvld;

  // ======================================================================
  // mac halves
  // ======================================================================

  logic [ATOMK_HALF-1:0][RESULT_WIDTH-1:0] a_data;
  logic [ATOMK_HALF-1:0]                   a_mask;
  logic                                    a_pvld;
  logic [ATOMK_HALF-1:0][RESULT_WIDTH-1:0] b_data;
  logic [ATOMK_HALF-1:0]                   b_mask;
  logic                                    b_pvld;

  // low kernels
  cmac_mac_half #(
    .ATOMC       (ATOMC),
    .ATOMK_HALF  (ATOMK_HALF),
    .DATA_WIDTH  (DATA_WIDTH),
    .MAC_LATENCY (MAC_LATENCY),
    .KERNEL_BASE (0)
  ) u_mac_a (
    .nvdla_core_clk (nvdla_core_clk),
    .reset          (reset),
    .sign_mode      (sign_mode),
    .atom           (u_atom),
    .res_data       (a_data),
    .res_mask       (a_mask),
    .res_pvld       (a_pvld)
  );

  // high kernels
  cmac_mac_half #(
    .ATOMC       (ATOMC),
    .ATOMK_HALF  (ATOMK_HALF),
    .DATA_WIDTH  (DATA_WIDTH),
    .MAC_LATENCY (MAC_LATENCY),
    .KERNEL_BASE (ATOMK_HALF)
  ) u_mac_b (
    .nvdla_core_clk (nvdla_core_clk),
    .reset          (reset),
    .sign_mode      (sign_mode),
    .atom           (u_atom),
    .res_data       (b_data),
    .res_mask       (b_mask),
    .res_pvld       (b_pvld)
  );

  // ======================================================================
  // output stage
  // ======================================================================

  cmac_rt_out #(
    .ATOMK        (ATOMK),
    .RESULT_WIDTH (RESULT_WIDTH),
    .MAC_LATENCY  (MAC_LATENCY),
    .RT_LATENCY   (RT_LATENCY)
  ) u_rt_out (
    .nvdla_core_clk (nvdla_core_clk),
    .reset          (reset),
    .in_pd          (in_pd),
    .in_pvld        (in_pvld),
    .a_data         (a_data),
    .a_mask         (a_mask),
    .a_pvld         (a_pvld),
    .b_data         (b_data),
    .b_mask         (b_mask),
    .b_pvld         (b_pvld),
    .mac2accu_data  (mac2accu_data),
    .mac2accu_mask  (mac2accu_mask),
    .mac2accu_pd    (mac2accu_pd),
    .mac2accu_pvld  (mac2accu_pvld),
    .dp2reg_done    (dp2reg_done)
  );

endmodule

`default_nettype wire

// File: verification/cmac_clk_gen.sv
`default_nettype none

// free running clock and a synchronous reset pulse at start
module cmac_clk_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic reset
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // high across the first RESET_CYCLES rising edges
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

// File: verification/tb_cmac_core.sv
`default_nettype none

// testbench for the cmac slice, default geometry
module tb_cmac_core
  import cmac_geom_pkg::*;
  import cmac_pkt_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ATOMC   = CMAC_ATOMC;
  localparam int ATOMK   = CMAC_ATOMK;
  localparam int DW      = CMAC_DATA_WIDTH;
  localparam int PDW     = CMAC_PD_WIDTH;
  // products need 2*DW bits, the channel sum adds log2(ATOMC)
  localparam int RW      = 2 * DW + $clog2(ATOMC);
  localparam int LATENCY = CMAC_MAC_LATENCY + CMAC_RT_LATENCY;

  // run length budget
  localparam int MAX_GAP        = 3;
  localparam int ATOM_BUDGET    = 200;
  localparam int IDLE_BUDGET    = 60;
  localparam int TIMEOUT_CYCLES = 4 + IDLE_BUDGET + ATOM_BUDGET * (1 + MAX_GAP) + 100;

  // one expected output beat
  typedef struct packed {
    logic [ATOMK*RW-1:0] data;
    logic [ATOMK-1:0]    mask;
    logic [PDW-1:0]      pd;
    int                  cycle;
  } beat_t;

  logic clk;
  logic reset;

  logic                        cfg_reg_en;
  logic                        cfg_sign;
  logic [ATOMC*DW-1:0]         in_dat;
  logic [ATOMC-1:0]            in_dat_mask;
  logic [ATOMK*ATOMC*DW-1:0]   in_wt;
  logic [ATOMK-1:0]            in_wt_mask;
  logic [PDW-1:0]              in_pd;
  logic                        in_pvld;
  wire  [ATOMK*RW-1:0]         mac2accu_data;
  wire  [ATOMK-1:0]            mac2accu_mask;
  wire  [PDW-1:0]              mac2accu_pd;
  wire                         mac2accu_pvld;
  wire                         dp2reg_done;

  beat_t      exp_q[$];
  cmac_sign_e cur_sign;
  int         seed = 8;
  int         cycle = 0;
  logic       done_due = 1'b0;

  int err_data  = 0;
  int err_mask  = 0;
  int err_pd    = 0;
  int err_time  = 0;
  int err_done  = 0;
  int err_proto = 0;
  int err_drain = 0;

  cmac_clk_gen #(.PERIOD_NS(40), .RESET_CYCLES(4)) u_clk_gen (
    .clk   (clk),
    .reset (reset)
  );

  cmac_core i_cmac_core (
    .nvdla_core_clk (clk),
    .reset          (reset),
    .cfg_reg_en     (cfg_reg_en),
    .cfg_sign       (cfg_sign),
    .in_dat         (in_dat),
    .in_dat_mask    (in_dat_mask),
    .in_wt          (in_wt),
    .in_wt_mask     (in_wt_mask),
    .in_pd          (in_pd),
    .in_pvld        (in_pvld),
    .mac2accu_data  (mac2accu_data),
    .mac2accu_mask  (mac2accu_mask),
    .mac2accu_pd    (mac2accu_pd),
    .mac2accu_pvld  (mac2accu_pvld),
    .dp2reg_done    (dp2reg_done)
  );

  // rising edges seen so far
  always @(posedge clk) cycle <= cycle + 1;

  // ======================================================================
  // reference model
  // ======================================================================

  // integer value of one operand under the given mode
  function automatic int operand_value(input logic [DW-1:0] x, input cmac_sign_e mode);
    int v;
    v = int'(x);
    // two's complement reading
    if (mode == sign_signed && x[DW-1]) v = v - (1 << DW);
    return v;
  endfunction

  // dot product per kernel over the enabled channels
  function automatic logic [ATOMK*RW-1:0] ref_dot(
    input logic [ATOMC*DW-1:0]       dat,
    input logic [ATOMC-1:0]          dat_mask,
    input logic [ATOMK*ATOMC*DW-1:0] wt,
    input logic [ATOMK-1:0]          wt_mask,
    input cmac_sign_e                mode
  );
    logic [ATOMK*RW-1:0] res;
    int                  sum;
    res = '0;
    for (int k = 0; k < ATOMK; k++) begin
      sum = 0;
      for (int c = 0; c < ATOMC; c++) begin
        if (dat_mask[c]) begin
          sum = sum + operand_value(dat[c*DW +: DW], mode) *
                      operand_value(wt[(k*ATOMC + c)*DW +: DW], mode);
        end
      end
      // disabled kernels carry no result
      if (wt_mask[k]) res[k*RW +: RW] = RW'(sum);
    end
    return res;
  endfunction

  // ======================================================================
  // stimulus tasks
  // ======================================================================

  // wait for an edge and return the strobes to idle
  task automatic next_cycle();
    @(posedge clk);
    in_pvld    <= 1'b0;
    cfg_reg_en <= 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic random_gap();
    int gap;
    gap = {$random(seed)} % (MAX_GAP + 1);
    idle(gap);
  endtask

  // present one atom on the current edge and record its expected beat
  task automatic drive_atom(
    input logic [ATOMC*DW-1:0]       dat,
    input logic [ATOMC-1:0]          dat_mask,
    input logic [ATOMK*ATOMC*DW-1:0] wt,
    input logic [ATOMK-1:0]          wt_mask,
    input logic [PDW-1:0]            pd
  );
    beat_t e;
    in_dat      <= dat;
    in_dat_mask <= dat_mask;
    in_wt       <= wt;
    in_wt_mask  <= wt_mask;
    in_pd       <= pd;
    in_pvld     <= 1'b1;
    e.data = ref_dot(dat, dat_mask, wt, wt_mask, cur_sign);
    e.mask = wt_mask;
    e.pd   = pd;
    // counter reads cycle+1 after this edge, the beat is high LATENCY cycles later
    e.cycle = cycle + 1 + LATENCY;
    exp_q.push_back(e);
  endtask

  task automatic make_random(
    input  logic                      rand_masks,
    output logic [ATOMC*DW-1:0]       dat,
    output logic [ATOMC-1:0]          dat_mask,
    output logic [ATOMK*ATOMC*DW-1:0] wt,
    output logic [ATOMK-1:0]          wt_mask,
    output logic [PDW-1:0]            pd
  );
    for (int c = 0; c < ATOMC; c++) dat[c*DW +: DW] = DW'($random(seed));
    for (int i = 0; i < ATOMK * ATOMC; i++) wt[i*DW +: DW] = DW'($random(seed));
    dat_mask = rand_masks ? ATOMC'($random(seed)) : '1;
    wt_mask  = rand_masks ? ATOMK'($random(seed)) : '1;
    pd       = PDW'($random(seed));
  endtask

  task automatic random_atom(input logic rand_masks);
    logic [ATOMC*DW-1:0]       dat;
    logic [ATOMC-1:0]          dat_mask;
    logic [ATOMK*ATOMC*DW-1:0] wt;
    logic [ATOMK-1:0]          wt_mask;
    logic [PDW-1:0]            pd;
    make_random(rand_masks, dat, dat_mask, wt, wt_mask, pd);
    next_cycle();
    drive_atom(dat, dat_mask, wt, wt_mask, pd);
  endtask

  // every operand the same, all channels and kernels on
  task automatic fill_atom(input logic [DW-1:0] d, input logic [DW-1:0] w,
                           input logic [PDW-1:0] pd);
    next_cycle();
    drive_atom({ATOMC{d}}, '1, {(ATOMK*ATOMC){w}}, '1, pd);
  endtask

  // strobe a new mode, an atom sampled on the same edge keeps the old one
  task automatic set_sign(input cmac_sign_e mode);
    logic [ATOMC*DW-1:0]       dat;
    logic [ATOMC-1:0]          dat_mask;
    logic [ATOMK*ATOMC*DW-1:0] wt;
    logic [ATOMK-1:0]          wt_mask;
    logic [PDW-1:0]            pd;
    make_random(1'b0, dat, dat_mask, wt, wt_mask, pd);
    next_cycle();
    cfg_reg_en <= 1'b1;
    cfg_sign   <= mode;
    drive_atom(dat, dat_mask, wt, wt_mask, pd);
    cur_sign = mode;
  endtask

  // ======================================================================
  // comparison, sampled mid cycle
  // ======================================================================

  always @(negedge clk) begin : p_compare
    beat_t e;
    if (!reset) begin
      // pulse owed one cycle after a beat with both end bits
      if (dp2reg_done !== done_due) begin
        $display("** Error @ %0t: dp2reg_done %b, expected %b", $time, dp2reg_done, done_due);
        err_done++;
      end
      done_due = 1'b0;
      if (mac2accu_pvld === 1'b1) begin
        if (exp_q.size() == 0) begin
          $display("unexpected output beat at %0t with no atom outstanding", $time);
          err_proto++;
        end else begin
          e = exp_q.pop_front();
          if (cycle != e.cycle) begin
            $display("** Error @ %0t: beat in cycle %0d, expected cycle %0d",
                     $time, cycle, e.cycle);
            err_time++;
          end
          if (mac2accu_mask !== e.mask) begin
            $display("** Error @ %0t: mask %h, expected %h", $time, mac2accu_mask, e.mask);
            err_mask++;
          end
          if (mac2accu_pd !== e.pd) begin
            $display("** Error @ %0t: pd %h, expected %h", $time, mac2accu_pd, e.pd);
            err_pd++;
          end
          for (int k = 0; k < ATOMK; k++) begin
            if (e.mask[k] && mac2accu_data[k*RW +: RW] !== e.data[k*RW +: RW]) begin
              $display("** Error @ %0t: kernel %0d data %h, expected %h", $time, k,
                       mac2accu_data[k*RW +: RW], e.data[k*RW +: RW]);
              err_data++;
            end
          end
          done_due = e.pd[PD_LAYER_END_BIT] & e.pd[PD_STRIPE_END_BIT];
        end
      end else begin
        if (mac2accu_pvld !== 1'b0) begin
          $display("mac2accu_pvld is unknown at %0t", $time);
          err_proto++;
        end
        if (mac2accu_mask !== '0) begin
          $display("** Error @ %0t: mask %h while idle", $time, mac2accu_mask);
          err_mask++;
        end
      end
    end
  end

  // ======================================================================
  // watchdog
  // ======================================================================

  initial begin : p_watchdog
    while (cycle < TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout: run passed %0d cycles with %0d beats still expected",
             TIMEOUT_CYCLES, exp_q.size());
    $display("TESTBENCH FAILED");
    $finish;
  end

  // ======================================================================
  // test sequence
  // ======================================================================

  initial begin : p_stim
    logic [PDW-1:0] pd_stripe;
    logic [PDW-1:0] pd_layer;
    logic [PDW-1:0] pd_both;
    int             total;
    cfg_reg_en  = 1'b0;
    cfg_sign    = 1'b0;
    in_dat      = '0;
    in_dat_mask = '0;
    in_wt       = '0;
    in_wt_mask  = '0;
    in_pd       = '0;
    in_pvld     = 1'b0;
    cur_sign    = sign_unsigned;
    pd_stripe = '0;
    pd_stripe[PD_STRIPE_END_BIT] = 1'b1;
    pd_layer = '0;
    pd_layer[PD_LAYER_END_BIT] = 1'b1;
    pd_both = pd_stripe | pd_layer;
    while (reset !== 1'b0) @(posedge clk);

    // quiet outputs after reset
    idle(10);

    // unsigned, back to back then with gaps
    repeat (40) random_atom(1'b0);
    repeat (40) begin
      random_atom(1'b0);
      random_gap();
    end

    // signed mode and the extreme operands
    idle(2);
    set_sign(sign_signed);
    fill_atom(8'h80, 8'h80, '0);
    fill_atom(8'h7f, 8'h80, '0);
    fill_atom(8'hff, 8'hff, '0);
    repeat (40) begin
      random_atom(1'b0);
      random_gap();
    end

    // random channel and kernel masks in both modes
    repeat (40) begin
      random_atom(1'b1);
      random_gap();
    end
    idle(1);
    set_sign(sign_unsigned);
    repeat (20) begin
      random_atom(1'b1);
      random_gap();
    end
    fill_atom(8'hff, 8'hff, '0);

    // end bits, only both together give a done pulse
    idle(3);
    fill_atom(8'h11, 8'h22, pd_stripe | 9'h01f);
    idle(2);
    fill_atom(8'h33, 8'h44, pd_layer | 9'h180);
    idle(3);
    fill_atom(8'h55, 8'h66, pd_both | 9'h003);
    idle(4);
    fill_atom(8'h01, 8'h02, pd_both);
    fill_atom(8'h03, 8'h04, pd_both);
    fill_atom(8'h05, 8'h06, pd_layer);

    // drain the pipeline and the done delay
    idle(LATENCY + 4);
    if (exp_q.size() != 0) begin
      $display("missing output: %0d expected beats never appeared", exp_q.size());
      err_drain = exp_q.size();
    end

    total = err_data + err_mask + err_pd + err_time + err_done + err_proto + err_drain;
    $display("errors: data %0d, mask %0d, pd %0d, timing %0d, done %0d, other %0d",
             err_data, err_mask, err_pd, err_time, err_done, err_proto + err_drain);
    if (total == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
verilog/cmac_geom_pkg.sv
verilog/cmac_pkt_pkg.sv
verilog/cmac_in_if.sv
verilog/cmac_mac_half.sv
verilog/cmac_rt_out.sv
verilog/cmac_core.sv
verification/cmac_clk_gen.sv
verification/tb_cmac_core.sv

// File: run_sim.sh
#!/bin/sh
# build and run the cmac_core testbench with verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_cmac_core
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module "$TOP" --Mdir "$BUILD_DIR" -f src.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the testbench reports its verdict in the log
if grep -q "TESTBENCH FAILED" "$LOG"; then
  echo "failure reported in $LOG"
  exit 1
fi

exit 0
